/* cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// ********************************************************************
// core widths
// ********************************************************************

`define WORD_W      32
`define REG_ADDR_W  5

// ********************************************************************
// memory map
// ********************************************************************

`define RAM_WORDS   256             // data ram depth in words
`define RESET_PC    32'h0000_0000   // first fetch address

`endif

/* isa_pkg.sv */
`include "cpu_config.svh"

package isa_pkg;

    typedef logic                     Bit_t;
    typedef logic [`WORD_W-1:0]       Word_t;
    typedef logic [`REG_ADDR_W-1:0]   Reg_addr_t;

    typedef enum logic [3:0] {
        OP_NOP,
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_SB,
        OP_SH,
        OP_SW
    } Oper_t;

    // writeback fields carried down the pipe
    typedef struct packed {
        Bit_t       wreg_write;
        Reg_addr_t  wreg_addr;
        Word_t      wreg_data;
        Bit_t       whilo;
        Word_t      hi;
        Word_t      lo;
        Bit_t       cp0_we;
        Reg_addr_t  cp0_addr;
        Word_t      cp0_data;
    } wb_bus_t;

    typedef struct packed {
        wb_bus_t    wb;
        Oper_t      oper;
        Word_t      mem_addr;       // byte address, low two bits unused
        Word_t      mem_data;       // store data
    } ex_mem_t;

endpackage

/* bus_pkg.sv */
package bus_pkg;

    import isa_pkg::*;

    // one enable per byte, lane 0 is bits 7:0
    typedef logic [3:0] Mask_t;

    // ********************************************************************
    // single-cycle ram request, strobes only
    // ********************************************************************
    typedef struct packed {
        Word_t      addr;
        Word_t      wdata;
        Bit_t       we;
        Bit_t       re;
        Mask_t      mask;
    } mem_req_t;

endpackage

/* stage_reg.sv */
module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      valid_i,
    input  payload_t  data_i,
    output logic      valid_o,
    output payload_t  data_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_o <= 1'b0;
            data_o  <= '0;      // clears write enables too
        end else begin
            valid_o <= valid_i;
            data_o  <= data_i;
        end
    end

endmodule

/* mem_stage.sv */
`include "cpu_config.svh"

module mem_stage (
    input  isa_pkg::ex_mem_t   ex_i,
    input  isa_pkg::Word_t     rdata_i,
    output bus_pkg::mem_req_t  req_o,
    output isa_pkg::wb_bus_t   wb_o
);

    import isa_pkg::*;

    always_comb begin
        // writeback, hilo and cp0 fields pass straight through
        wb_o        = ex_i.wb;

        req_o.addr  = ex_i.mem_addr;
        req_o.wdata = ex_i.mem_data;
        req_o.we    = 1'b0;
        req_o.re    = 1'b0;
        req_o.mask  = 4'b0000;

        case (ex_i.oper)
            OP_LB: begin
                req_o.re       = 1'b1;
                req_o.mask     = 4'b0001;
                wb_o.wreg_data = {{(`WORD_W-8){rdata_i[7]}}, rdata_i[7:0]};
            end
            OP_LBU: begin
                req_o.re       = 1'b1;
                req_o.mask     = 4'b0001;
                wb_o.wreg_data = {{(`WORD_W-8){1'b0}}, rdata_i[7:0]};
            end
            OP_LH: begin
                req_o.re       = 1'b1;
                req_o.mask     = 4'b0011;
                wb_o.wreg_data = {{(`WORD_W-16){rdata_i[15]}}, rdata_i[15:0]};
            end
            OP_LHU: begin
                req_o.re       = 1'b1;
                req_o.mask     = 4'b0011;
                wb_o.wreg_data = {{(`WORD_W-16){1'b0}}, rdata_i[15:0]};
            end
            OP_LW: begin
                req_o.re       = 1'b1;
                req_o.mask     = 4'b1111;
                wb_o.wreg_data = rdata_i;
            end
            // stores only drive the low lanes
            OP_SB: begin
                req_o.we   = 1'b1;
                req_o.mask = 4'b0001;
            end
            OP_SH: begin
                req_o.we   = 1'b1;
                req_o.mask = 4'b0011;
            end
            OP_SW: begin
                req_o.we   = 1'b1;
                req_o.mask = 4'b1111;
            end
            default: begin
            end
        endcase
    end

endmodule

/* fetch_port.sv */
`include "cpu_config.svh"

module fetch_port (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               fetch_en_i,
    input  logic               grant_i,
    input  isa_pkg::Word_t     rdata_i,
    output bus_pkg::mem_req_t  req_o,
    output isa_pkg::Word_t     instr_o,
    output logic               instr_valid_o,
    output isa_pkg::Word_t     pc_o
);

    import isa_pkg::*;

    Word_t pc_q;
    logic  fire;    // requesting and granted

    assign fire = fetch_en_i & grant_i;

    always_comb begin
        req_o.addr  = pc_q;
        req_o.wdata = '0;
        req_o.we    = 1'b0;
        req_o.re    = fetch_en_i;
        req_o.mask  = fetch_en_i ? 4'b1111 : 4'b0000;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= `RESET_PC;
        end else if (fire) begin
            pc_q <= pc_q + Word_t'(4);
        end
    end

    assign pc_o = pc_q;

    // ********************************************************************
    // instruction register, valid only after a granted read
    // ********************************************************************
    stage_reg #(.payload_t(Word_t)) u_instr_reg (
        .clk     (clk),
        .reset_i (reset_i),
        .valid_i (fire),
        .data_i  (rdata_i),
        .valid_o (instr_valid_o),
        .data_o  (instr_o)
    );

endmodule

/* mem_arbiter.sv */
module mem_arbiter (
    input  bus_pkg::mem_req_t  data_req_i,
    input  bus_pkg::mem_req_t  fetch_req_i,
    output bus_pkg::mem_req_t  ram_req_o,
    output logic               fetch_grant_o
);

    logic data_active;

    // data port has fixed priority
    assign data_active = data_req_i.re | data_req_i.we;

    always_comb begin
        if (data_active) begin
            ram_req_o = data_req_i;
        end else begin
            ram_req_o = fetch_req_i;
        end
    end

    // level grant; fetch stalls for the whole data cycle
    assign fetch_grant_o = ~data_active;

endmodule

/* data_ram.sv */
`include "cpu_config.svh"

module data_ram (
    input  logic               clk,
    input  bus_pkg::mem_req_t  req_i,
    output isa_pkg::Word_t     rdata_o
);

    import isa_pkg::*;

    localparam int IDX_W = $clog2(`RAM_WORDS);
    localparam int LANES = `WORD_W / 8;

    Word_t            mem [`RAM_WORDS];
    logic [IDX_W-1:0] word_idx;

    assign word_idx = req_i.addr[IDX_W+1:2];    // byte offset ignored

    initial begin
        for (int i = 0; i < `RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign rdata_o = mem[word_idx];

    // ********************************************************************
    // byte-lane write
    // ********************************************************************
    always_ff @(posedge clk) begin
        if (req_i.we) begin
            for (int b = 0; b < LANES; b++) begin
                if (req_i.mask[b]) begin
                    mem[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    a_write_has_lanes: assert property (@(posedge clk) req_i.we |-> (req_i.mask != '0))
        else $error("data_ram: write with empty mask");

endmodule

/* mem_subsys_top.sv */
module mem_subsys_top (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               ex_valid_i,
    input  isa_pkg::ex_mem_t   ex_i,
    input  logic               fetch_en_i,
    output logic               wb_valid_o,
    output isa_pkg::wb_bus_t   wb_o,
    output isa_pkg::Word_t     instr_o,
    output logic               instr_valid_o,
    output isa_pkg::Word_t     pc_o
);

    import isa_pkg::*;
    import bus_pkg::*;

    ex_mem_t  ex_gated;
    wb_bus_t  wb_comb;
    mem_req_t data_req;
    mem_req_t fetch_req;
    mem_req_t ram_req;
    Word_t    ram_rdata;
    logic     fetch_grant;

    // idle slot must not touch memory
    always_comb begin
        ex_gated = ex_i;
        if (!ex_valid_i) begin
            ex_gated.oper = OP_NOP;
        end
    end

    mem_stage u_mem_stage (
        .ex_i    (ex_gated),
        .rdata_i (ram_rdata),
        .req_o   (data_req),
        .wb_o    (wb_comb)
    );

    fetch_port u_fetch (
        .clk           (clk),
        .reset_i       (reset_i),
        .fetch_en_i    (fetch_en_i),
        .grant_i       (fetch_grant),
        .rdata_i       (ram_rdata),
        .req_o         (fetch_req),
        .instr_o       (instr_o),
        .instr_valid_o (instr_valid_o),
        .pc_o          (pc_o)
    );

    mem_arbiter u_arbiter (
        .data_req_i    (data_req),
        .fetch_req_i   (fetch_req),
        .ram_req_o     (ram_req),
        .fetch_grant_o (fetch_grant)
    );

    data_ram u_ram (
        .clk     (clk),
        .req_i   (ram_req),
        .rdata_o (ram_rdata)
    );

    // mem/wb boundary
    stage_reg #(.payload_t(wb_bus_t)) u_wb_reg (
        .clk     (clk),
        .reset_i (reset_i),
        .valid_i (ex_valid_i),
        .data_i  (wb_comb),
        .valid_o (wb_valid_o),
        .data_o  (wb_o)
    );

endmodule

/* tb_mem_subsys.sv */
`include "cpu_config.svh"

module tb_mem_subsys;

    import isa_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int TEST_CYCLES  = RESET_CYCLES + 40 + 60 + 60 + 150 + 100;
    localparam int TIMEOUT      = TEST_CYCLES * 20 + 1000;

    logic    clk;
    logic    reset;
    logic    ex_valid;
    ex_mem_t ex;
    logic    fetch_en;
    logic    wb_valid;
    wb_bus_t wb;
    Word_t   instr;
    logic    instr_valid;
    Word_t   pc;

    logic [31:0] lfsr_state;
    logic [7:0]  model_mem [`RAM_WORDS][4];    // byte lanes per word
    Word_t       model_pc;

    mem_subsys_top u_dut (
        .clk           (clk),
        .reset_i       (reset),
        .ex_valid_i    (ex_valid),
        .ex_i          (ex),
        .fetch_en_i    (fetch_en),
        .wb_valid_o    (wb_valid),
        .wb_o          (wb),
        .instr_o       (instr),
        .instr_valid_o (instr_valid),
        .pc_o          (pc)
    );

    always #10 clk = ~clk;

    // ********************************************************************
    // random source
    // ********************************************************************
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic wb_bus_t random_wb();
        wb_bus_t     w;
        logic [31:0] a;
        logic [31:0] b;
        a            = rand_bits(5);
        b            = rand_bits(5);
        w.wreg_write = rand_bits(1) != 0;
        w.wreg_addr  = a[4:0];
        w.wreg_data  = rand_bits(32);
        w.whilo      = rand_bits(1) != 0;
        w.hi         = rand_bits(32);
        w.lo         = rand_bits(32);
        w.cp0_we     = rand_bits(1) != 0;
        w.cp0_addr   = b[4:0];
        w.cp0_data   = rand_bits(32);
        return w;
    endfunction

    // codes 0..4 are loads, 5..7 stores
    function automatic Oper_t oper_from_code(int code);
        case (code)
            0: return OP_LB;
            1: return OP_LBU;
            2: return OP_LH;
            3: return OP_LHU;
            4: return OP_LW;
            5: return OP_SB;
            6: return OP_SH;
            default: return OP_SW;
        endcase
    endfunction

    function automatic Oper_t pick_oper(int mode);
        case (mode)
            1: return oper_from_code(5 + int'(rand_bits(2)) % 3);
            2: return oper_from_code(int'(rand_bits(3)) % 5);
            3: return oper_from_code(int'(rand_bits(3)));
            4: return (rand_bits(2) == 0) ? oper_from_code(int'(rand_bits(3))) : OP_NOP;
            default: return OP_NOP;
        endcase
    endfunction

    // ********************************************************************
    // reference model
    // ********************************************************************
    function automatic int word_index(Word_t a);
        return int'((a >> 2) % `RAM_WORDS);
    endfunction

    function automatic Word_t model_word(int idx);
        return {model_mem[idx][3], model_mem[idx][2], model_mem[idx][1], model_mem[idx][0]};
    endfunction

    function automatic Word_t load_result(Oper_t op, Word_t w);
        case (op)
            OP_LB:   return Word_t'($signed(w[7:0]));
            OP_LBU:  return Word_t'(w[7:0]);
            OP_LH:   return Word_t'($signed(w[15:0]));
            OP_LHU:  return Word_t'(w[15:0]);
            default: return w;
        endcase
    endfunction

    function automatic int store_lanes(Oper_t op);
        case (op)
            OP_SB:   return 1;
            OP_SH:   return 2;
            OP_SW:   return 4;
            default: return 0;
        endcase
    endfunction

    // ********************************************************************
    // compare tasks
    // ********************************************************************
    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_wb(string name, wb_bus_t exp, wb_bus_t act);
        if (act !== exp) begin
            fail_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_word(string name, Word_t exp, Word_t act);
        if (act !== exp) begin
            fail_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            fail_run($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // one random op per cycle, results checked one cycle later
    task automatic run_phase(string name, int cycles, int mode);
        ex_mem_t nxt;
        logic    nxt_valid;
        logic    nxt_fetch;
        logic    fire;
        wb_bus_t exp_wb;
        Word_t   exp_instr;
        Word_t   addr_bits;
        int      idx;
        for (int c = 0; c < cycles; c++) begin
            addr_bits    = rand_bits(6);            // 16 words plus byte offset
            nxt.wb       = random_wb();
            nxt.oper     = pick_oper(mode);
            nxt.mem_addr = addr_bits;
            nxt.mem_data = rand_bits(32);
            nxt_valid    = rand_bits(3) != 0;
            nxt_fetch    = rand_bits(3) != 0;
            if (mode == 0) begin
                nxt_fetch = 1'b0;     // pc stays low until stores land
            end
            fire         = nxt_fetch && !(nxt_valid && nxt.oper != OP_NOP);
            idx          = word_index(nxt.mem_addr);
            exp_wb       = nxt.wb;
            exp_instr    = '0;
            if (nxt_valid && nxt.oper inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW}) begin
                exp_wb.wreg_data = load_result(nxt.oper, model_word(idx));
            end
            if (fire) begin
                exp_instr = model_word(word_index(model_pc));
                model_pc  = model_pc + 32'd4;
            end
            if (nxt_valid) begin
                for (int b = 0; b < store_lanes(nxt.oper); b++) begin
                    model_mem[idx][b] = nxt.mem_data[8*b +: 8];
                end
            end
            ex       = nxt;
            ex_valid = nxt_valid;
            fetch_en = nxt_fetch;
            @(posedge clk);
            #2;
            check_bit({name, " wb_valid"}, nxt_valid, wb_valid);
            check_wb({name, " wb"}, exp_wb, wb);
            check_bit({name, " instr_valid"}, fire, instr_valid);
            if (fire) begin
                check_word({name, " instr"}, exp_instr, instr);
            end
            check_word({name, " pc"}, model_pc, pc);
        end
    endtask

    initial begin
        #(TIMEOUT);
        fail_run($sformatf("watchdog expired after %0d time units, tests did not finish",
                           TIMEOUT));
    end

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        ex_valid   = 1'b0;
        ex         = '0;
        fetch_en   = 1'b0;
        lfsr_state = 32'hb3e8;
        model_pc   = `RESET_PC;
        for (int i = 0; i < `RAM_WORDS; i++) begin
            for (int b = 0; b < 4; b++) begin
                model_mem[i][b] = 8'h00;
            end
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;
        check_bit("reset wb_valid", 1'b0, wb_valid);
        check_bit("reset instr_valid", 1'b0, instr_valid);
        check_bit("reset wreg_write", 1'b0, wb.wreg_write);
        check_bit("reset whilo", 1'b0, wb.whilo);
        check_bit("reset cp0_we", 1'b0, wb.cp0_we);
        check_word("reset pc", `RESET_PC, pc);

        run_phase("pass_through", 40, 0);
        run_phase("stores", 60, 1);
        run_phase("loads", 60, 2);
        run_phase("load_store_mix", 150, 3);
        run_phase("fetch_arb", 100, 4);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* sources.f */
+incdir+.
isa_pkg.sv
bus_pkg.sv
stage_reg.sv
mem_stage.sv
fetch_port.sv
mem_arbiter.sv
data_ram.sv
mem_subsys_top.sv
tb_mem_subsys.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_subsys \
		-f sources.f -o tb_sim
	./obj_dir/tb_sim

clean:
	rm -rf obj_dir
